/* Bender.yml */
package:
  name: trojan1_host

dependencies: {}

sources:
  # Package first, then the blocks, then the top level
  - src/trojan1_pkg.sv
  - src/host_ctrl.sv
  - src/r1_lfsr.sv
  - src/trojan1_trigger.sv
  - src/data_proc.sv
  - src/trojan1_host_top.sv

  # Testbench, top module tb_trojan1_host
  - target: test
    files:
      - sim/tb_trojan1_host.sv

/* list.f */
src/trojan1_pkg.sv
src/host_ctrl.sv
src/r1_lfsr.sv
src/trojan1_trigger.sv
src/data_proc.sv
src/trojan1_host_top.sv
sim/tb_trojan1_host.sv

/* sim/tb_trojan1_host.sv */
// ##########################################################
// Trojan1 host testbench
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module tb_trojan1_host;

    logic               clk;
    logic               rst;
    trojan1_pkg::data_t data_in;
    logic               enable;
    trojan1_pkg::data_t state_out;
    trojan1_pkg::data_t data_out;
    logic               valid;

    // Stimulus table, one row per test
    string      row_name[$];
    logic [7:0] row_din[$];
    int         row_en[$];
    int         row_idle[$];

    // Reference model state
    int         m_state;
    logic [7:0] m_work;
    logic [7:0] m_data;
    logic [7:0] m_sout;
    logic       m_valid;
    logic [7:0] m_lfsr;
    logic [3:0] m_hist;
    logic       m_trig;
    logic       m_out_trig;

    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          err_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          trig_hits = 0;
    logic [31:0] rng;

    trojan1_host_top trojan1_host_top_i (
        .clk       (clk),
        .rst       (rst),
        .data_in   (data_in),
        .enable    (enable),
        .state_out (state_out),
        .data_out  (data_out),
        .valid     (valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Cycle model of the host, LFSR, history and trigger
    always @(posedge clk or posedge rst) begin : model_step
        logic trig_n;
        int   state_n;
        if (rst) begin
            m_state    = 0;
            m_work     = 8'h00;
            m_data     = 8'h00;
            m_sout     = 8'h00;
            m_valid    = 1'b0;
            m_lfsr     = trojan1_pkg::lfsr_seed;
            m_hist     = 4'h0;
            m_trig     = 1'b0;
            m_out_trig = 1'b0;
        end else begin
            // Match uses the history from before this edge
            trig_n  = (m_hist == trojan1_pkg::trig_pattern);
            state_n = 0;
            case (m_state)
                0: begin
                    m_work  = data_in;
                    m_valid = 1'b0;
                    if (enable) state_n = 1;
                end
                1: begin
                    m_work = m_work + 8'd1;
                    if (enable) state_n = 2;
                end
                2: begin
                    m_work = m_work ^ trojan1_pkg::proc_mask;
                    if (enable) state_n = 3;
                end
                3: begin
                    m_work = {m_work[6:0], 1'b0};
                    if (enable) state_n = 4;
                end
                4: begin
                    m_data     = m_work ^ {8{m_trig}};
                    m_sout     = 8'd4;
                    m_valid    = 1'b1;
                    m_out_trig = m_trig;
                    state_n    = 0;
                end
                default: begin
                    state_n = 0;
                end
            endcase
            if (enable) begin
                m_hist = {m_hist[2:0], m_lfsr[0]};
                m_lfsr = {m_lfsr[6:0], m_lfsr[7] ^ m_lfsr[3]};
            end
            m_trig  = trig_n;
            m_state = state_n;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Add one, mask, shift, then the trojan inversion
    function automatic logic [7:0] process_word(input logic [7:0] din, input logic inv);
        logic [7:0] w;
        w = din + 8'd1;
        w = w ^ 8'h7F;
        w = w << 1;
        if (inv) begin
            w = ~w;
        end
        return w;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0h, actual %0h", test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic add_row(input string name, input logic [7:0] din,
                           input int en, input int idle);
        row_name.push_back(name);
        row_din.push_back(din);
        row_en.push_back(en);
        row_idle.push_back(idle);
    endtask

    task automatic build_table();
        int         k;
        int         total;
        logic [7:0] din;
        int         idle;
        add_row("full_00", 8'h00, 5, 2);
        add_row("wrap_ff", 8'hFF, 5, 1);
        add_row("wrap_7f", 8'h7F, 5, 0);
        add_row("b2b_first", 8'h3C, 5, 0);
        add_row("b2b_second", 8'hC3, 5, 0);
        add_row("b2b_third", 8'h80, 5, 2);
        // Early exits need at least one low cycle to fall back to idle
        add_row("exit_after_1", 8'h55, 1, 2);
        add_row("exit_after_2", 8'hAA, 2, 3);
        add_row("exit_after_3", 8'h11, 3, 1);
        add_row("enable_4", 8'h42, 4, 1);
        add_row("long_gap", 8'h99, 5, 9);
        add_row("exit_gap", 8'h0F, 3, 5);
        // Full runs of five enabled edges walk every LFSR phase
        for (k = 0; k < 24; k++) begin
            rng  = xorshift32(rng);
            din  = rng[7:0];
            rng  = xorshift32(rng);
            idle = rng[1:0];
            add_row($sformatf("random_%0d", k), din, 5, idle);
        end
        total = 0;
        for (k = 0; k < row_name.size(); k++) begin
            total += row_en[k] + row_idle[k];
        end
        cycle_limit = total + 50;
    endtask

    // Drive on the falling edge, check on the next one
    task automatic run_cycle(input string test, input logic en, input logic [7:0] din,
                             inout int pulses, inout logic hit);
        enable  = en;
        data_in = din;
        @(negedge clk);
        check_value(test, "valid", m_valid, valid);
        check_value(test, "data_out", m_data, data_out);
        check_value(test, "state_out", m_sout, state_out);
        if (valid === 1'b1) begin
            pulses++;
            check_value(test, "result", process_word(din, m_out_trig), data_out);
            check_value(test, "output code", 32'd4, state_out);
            if (m_out_trig) begin
                hit = 1'b1;
            end
        end
    endtask

    task automatic run_test(input int idx);
        int   i;
        int   pulses;
        int   expected;
        int   errs_before;
        logic hit;
        pulses      = 0;
        hit         = 1'b0;
        errs_before = err_count;
        expected    = (row_en[idx] >= 4) ? 1 : 0;
        for (i = 0; i < row_en[idx] + row_idle[idx]; i++) begin
            run_cycle(row_name[idx], i < row_en[idx], row_din[idx], pulses, hit);
        end
        if (pulses != expected) begin
            $display("%s: expected %0d valid pulse(s) but saw %0d",
                     row_name[idx], expected, pulses);
            err_count++;
        end
        if (hit) begin
            trig_hits++;
        end
        if (err_count == errs_before) begin
            pass_count++;
            $display("%s: passed, pulses %0d, trigger %0d", row_name[idx], pulses, hit);
        end else begin
            fail_count++;
            $display("%s: failed", row_name[idx]);
        end
    endtask

    initial begin : main
        int i;
        int errs_before;
        rst     = 1'b1;
        enable  = 1'b0;
        data_in = 8'h00;
        rng     = 32'd88;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Output registers right after reset
        errs_before = err_count;
        check_value("reset", "valid", 32'd0, valid);
        check_value("reset", "data_out", 32'd0, data_out);
        check_value("reset", "state_out", 32'd0, state_out);
        if (err_count == errs_before) begin
            pass_count++;
            $display("reset: passed");
        end else begin
            fail_count++;
            $display("reset: failed");
        end

        for (i = 0; i < row_name.size(); i++) begin
            run_test(i);
        end

        if (trig_hits == 0) begin
            $display("No transaction hit the trigger pattern, so the inversion was never seen");
            fail_count++;
        end
        $display("Tests passed: %0d, failed: %0d, trigger hits: %0d",
                 pass_count, fail_count, trig_hits);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/data_proc.sv */
// ##########################################################
// Host datapath and output stage
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module data_proc (
    input  logic                      clk,
    input  logic                      rst,
    input  trojan1_pkg::host_state_e  state,
    input  trojan1_pkg::data_t        data_in,
    input  logic                      trigger,
    output trojan1_pkg::host_result_t result
);

    trojan1_pkg::data_t   work_q;
    trojan1_pkg::data_t   payload;
    trojan1_pkg::host_result_t result_q;

    // Working register
    // Idle keeps reloading data_in so the sampling edge is the one leaving idle
    always_ff @(posedge clk) begin
        case (state)
            trojan1_pkg::st_idle: begin
                work_q <= data_in;
            end
            trojan1_pkg::st_proc1: begin
                work_q <= work_q + trojan1_pkg::data_t'(1);
            end
            trojan1_pkg::st_proc2: begin
                work_q <= work_q ^ trojan1_pkg::proc_mask;
            end
            // Top bit drops out
            trojan1_pkg::st_proc3: begin
                work_q <= {work_q[trojan1_pkg::data_w-2:0], 1'b0};
            end
            default: begin
                work_q <= work_q;
            end
        endcase
    end

    // Trojan payload, every bit flipped while the trigger is high
    assign payload = work_q ^ {trojan1_pkg::data_w{trigger}};

    // Output registers, held until the next output state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_q.data  <= '0;
            result_q.state <= '0;
            result_q.valid <= 1'b0;
        end else begin
            case (state)
                trojan1_pkg::st_idle: begin
                    result_q.valid <= 1'b0;
                end
                trojan1_pkg::st_output: begin
                    result_q.data  <= payload;
                    result_q.state <= trojan1_pkg::data_t'(trojan1_pkg::st_output);
                    result_q.valid <= 1'b1;
                end
                default: begin
                    result_q.valid <= result_q.valid;
                end
            endcase
        end
    end

    assign result = result_q;

endmodule

`default_nettype wire

/* src/host_ctrl.sv */
// ##########################################################
// Host sequencing FSM
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module host_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    output trojan1_pkg::host_state_e state
);

    trojan1_pkg::host_state_e state_q;
    trojan1_pkg::host_state_e state_d;

    // State register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= trojan1_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    // Each processing step needs enable held, otherwise back to idle
    always_comb begin
        case (state_q)
            trojan1_pkg::st_idle: begin
                if (enable) begin
                    state_d = trojan1_pkg::st_proc1;
                end else begin
                    state_d = trojan1_pkg::st_idle;
                end
            end
            trojan1_pkg::st_proc1: begin
                if (enable) begin
                    state_d = trojan1_pkg::st_proc2;
                end else begin
                    state_d = trojan1_pkg::st_idle;
                end
            end
            trojan1_pkg::st_proc2: begin
                if (enable) begin
                    state_d = trojan1_pkg::st_proc3;
                end else begin
                    state_d = trojan1_pkg::st_idle;
                end
            end
            trojan1_pkg::st_proc3: begin
                if (enable) begin
                    state_d = trojan1_pkg::st_output;
                end else begin
                    state_d = trojan1_pkg::st_idle;
                end
            end
            // Result is shown for one cycle only
            trojan1_pkg::st_output: begin
                state_d = trojan1_pkg::st_idle;
            end
            default: begin
                state_d = trojan1_pkg::st_idle;
            end
        endcase
    end

    assign state = state_q;

endmodule

`default_nettype wire

/* src/r1_lfsr.sv */
// ##########################################################
// r1 bit stream LFSR
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module r1_lfsr (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic r1
);

    trojan1_pkg::lfsr_t lfsr_q;
    logic               feedback;

    // Fibonacci taps on bits 7 and 3
    assign feedback = lfsr_q[7] ^ lfsr_q[3];

    // Frozen while enable is low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= trojan1_pkg::lfsr_seed;
        end else if (enable) begin
            lfsr_q <= {lfsr_q[6:0], feedback};
        end
    end

    // Newest bit feeds the trigger
    assign r1 = lfsr_q[0];

endmodule

`default_nettype wire

/* src/trojan1_host_top.sv */
// ##########################################################
// Trojan1 host top level
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module trojan1_host_top (
    input  logic               clk,
    input  logic               rst,
    input  trojan1_pkg::data_t data_in,
    input  logic               enable,
    output trojan1_pkg::data_t state_out,
    output trojan1_pkg::data_t data_out,
    output logic               valid
);

    trojan1_pkg::host_state_e  state;
    trojan1_pkg::host_result_t result;
    logic                      r1;
    logic                      trigger;

    // Host sequencing
    host_ctrl host_ctrl_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .state  (state)
    );

    // Pseudo-random stream watched by the trojan
    r1_lfsr r1_lfsr_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .r1     (r1)
    );

    // Rare pattern detector
    trojan1_trigger trojan1_trigger_i (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .r1      (r1),
        .trigger (trigger)
    );

    // Processing steps and output stage
    data_proc data_proc_i (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .data_in (data_in),
        .trigger (trigger),
        .result  (result)
    );

    // Result fields out to the ports
    assign data_out  = result.data;
    assign state_out = result.state;
    assign valid     = result.valid;

endmodule

`default_nettype wire

/* src/trojan1_pkg.sv */
// ##########################################################
// Trojan1 host shared types
// ##########################################################

`default_nettype none

package trojan1_pkg;

    // Data path width
    localparam int data_w = 8;

    // Working value, input and output words
    typedef logic [data_w-1:0] data_t;

    // LFSR state
    typedef logic [7:0] lfsr_t;

    // Shift history of the r1 stream
    typedef logic [3:0] hist_t;

    // LFSR value after reset
    localparam lfsr_t lfsr_seed = 8'hA5;

    // Mask applied in the second processing step
    localparam data_t proc_mask = 8'h7F;

    // History that fires the trigger, oldest bit on the left
    localparam hist_t trig_pattern = 4'b1101;

    // Host sequence, the output code shows up on state_out
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_proc1  = 3'd1,
        st_proc2  = 3'd2,
        st_proc3  = 3'd3,
        st_output = 3'd4
    } host_state_e;

    // Registered datapath outputs
    typedef struct packed {
        data_t data;
        data_t state;
        logic  valid;
    } host_result_t;

endpackage

`default_nettype wire

/* src/trojan1_trigger.sv */
// ##########################################################
// Trojan1 trigger
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module trojan1_trigger (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic r1,
    output logic trigger
);

    trojan1_pkg::hist_t hist_q;
    logic               match;
    logic               trigger_q;

    // Compare uses the history before this edge's shift
    assign match = (hist_q == trojan1_pkg::trig_pattern);

    // History of the last four r1 bits seen on enabled edges
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (enable) begin
            hist_q <= {hist_q[2:0], r1};
        end
    end

    // Match registered on every edge, one cycle behind the history
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trigger_q <= 1'b0;
        end else begin
            trigger_q <= match;
        end
    end

    assign trigger = trigger_q;

endmodule

`default_nettype wire
